//--- hdl/neoSupport_settings.svh
// Support logic settings
// Widths, SDRAM memory map bases and save-image sector limits
`ifndef NEOSUPPORT_SETTINGS_SVH
`define NEOSUPPORT_SETTINGS_SVH

// ==========================================================
// Widths
// ==========================================================

// SDRAM word address
`define NEO_SDRAM_AW 25
// Host download address
`define NEO_IOCTL_AW 25
// Host sector address
`define NEO_LBA_W 32
// 68k work RAM word address (32k words)
`define NEO_WRAM_AW 15
// Work RAM clear counter, one full 16-bit sweep
`define NEO_CLEAR_W 16

// ==========================================================
// SDRAM memory map bases
// ==========================================================

`define NEO_BASE_SPROM 25'h0600000
`define NEO_BASE_SFIX 25'h0620000
`define NEO_BASE_S1 25'h0680000
`define NEO_BASE_P1B 25'h0080000
`define NEO_BASE_P2 25'h0200000
// C ROMs fill the top of SDRAM
`define NEO_BASE_CROM 25'h0800000

// Last save-image sector
// 8kB card image on CD systems
`define NEO_LAST_SECTOR_CD 8'd15
// 64kB backup RAM plus 2kB card on cartridge systems
`define NEO_LAST_SECTOR_CART 8'd131

`endif

//--- hdl/neoPkg.sv
// Shared types of the console support logic
// System types, download indices and data words

`include "neoSupport_settings.svh"

package neoPkg;

	// ==========================================================
	// System selection
	// ==========================================================

	// Bit 1 set on both CD variants
	typedef enum logic [1:0]
	{
		CONSOLE = 2'd0,
		ARCADE = 2'd1,
		CD = 2'd2,
		CDZ = 2'd3
	} systemTypeT;

	// Host download slots
	// Any index of CROM or above carries a C ROM
	typedef enum logic [7:0]
	{
		SPROM = 8'd0,
		LOROM = 8'd1,
		SFIX = 8'd2,
		P1A = 8'd4,
		P1B = 8'd5,
		P2 = 8'd6,
		S1 = 8'd8,
		M1 = 8'd9,
		CROM = 8'd64
	} romIndexT;

	// ==========================================================
	// Data words
	// ==========================================================

	typedef logic [`NEO_SDRAM_AW-1:0] sdramAddrT;

	// Dark bit, RGB LSBs, then 4 bits per channel
	typedef logic [15:0] palEntryT;

	// One DAC channel
	typedef logic [7:0] rgbT;

	typedef logic [15:0] wramWordT;

endpackage

//--- hdl/romLoadMapper.sv
// ROM download mapper
// Maps host download writes into SDRAM and the on-chip ROMs
`timescale 1ns/100ps
`include "neoSupport_settings.svh"

module romLoadMapper
(
	input logic clk_sys,
	input logic nBNKB,
	input logic downloading,
	input neoPkg::romIndexT ioctlIndex,
	input logic [`NEO_IOCTL_AW-1:0] ioctlAddr,
	input logic ioctlWr,
	input neoPkg::systemTypeT systemType,
	output neoPkg::sdramAddrT sdramAddr,
	output logic sdramWe,
	output logic loRomWe,
	output logic z80RomWe
);

	neoPkg::sdramAddrT mappedAddr;
	logic isCdType;
	logic loadWrite;
	logic sdramPass;

	// Both CD variants share one policy
	assign isCdType = (systemType == neoPkg::CD) || (systemType == neoPkg::CDZ);
	assign loadWrite = downloading & ioctlWr;

	// CD systems only load the BIOS from the host
	// Cartridges keep LO and M1 in their own ROMs
	assign sdramPass = isCdType ? (ioctlIndex == neoPkg::SPROM) :
		((ioctlIndex != neoPkg::LOROM) && (ioctlIndex != neoPkg::M1));

	// Memory map per download slot
	always_comb
	begin
		case (ioctlIndex)
			neoPkg::SPROM: mappedAddr = `NEO_BASE_SPROM + neoPkg::sdramAddrT'(ioctlAddr[18:0]);
			neoPkg::S1: mappedAddr = `NEO_BASE_S1 + neoPkg::sdramAddrT'(ioctlAddr[18:0]);
			neoPkg::SFIX: mappedAddr = `NEO_BASE_SFIX + neoPkg::sdramAddrT'(ioctlAddr[16:0]);
			// P1 first half or whole
			neoPkg::P1A: mappedAddr = neoPkg::sdramAddrT'(ioctlAddr[19:0]);
			neoPkg::P1B: mappedAddr = `NEO_BASE_P1B + neoPkg::sdramAddrT'(ioctlAddr[18:0]);
			neoPkg::P2: mappedAddr = ioctlAddr + `NEO_BASE_P2;
			default:
			begin
				// C ROM pairs interleave as even and odd words
				// Upper index bits pick the 1M slot
				if (ioctlIndex >= neoPkg::CROM)
					mappedAddr = `NEO_BASE_CROM + {ioctlAddr[23:0], 1'b0} +
						{ioctlIndex[5:1], 20'h00000} + {23'h000000, ioctlIndex[0], 1'b0};
				else
					mappedAddr = '0;
			end
		endcase
	end

	// Address follows the write by one cycle
	always_ff @(posedge clk_sys)
		sdramAddr <= mappedAddr;

	// Write strobes, one cycle behind the host
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			sdramWe <= 1'b0;
			loRomWe <= 1'b0;
			z80RomWe <= 1'b0;
		end
		else
		begin
			sdramWe <= loadWrite & sdramPass;
			loRomWe <= loadWrite & (ioctlIndex == neoPkg::LOROM);
			z80RomWe <= loadWrite & (ioctlIndex == neoPkg::M1);
		end
	end

endmodule

//--- hdl/saveSequencer.sv
// Save image sequencer
// Moves the card or backup image one sector at a time over host block requests
`timescale 1ns/100ps
`include "neoSupport_settings.svh"

module saveSequencer
(
	input logic clk_sys,
	input logic nBNKB,
	input logic downloading,
	input logic imgMounted,
	input logic imgSizeNonzero,
	input logic imgReadonly,
	input logic saveReq,
	input neoPkg::systemTypeT systemType,
	input logic sdAck,
	output logic sdRd,
	output logic sdWr,
	output logic [`NEO_LBA_W-1:0] sdLba
);

	typedef enum logic
	{
		IDLE = 1'b0,
		XFER = 1'b1
	} seqStateT;

	seqStateT state;
	logic enable;
	logic loadPending;
	logic loading;
	logic downloadingPrev;
	logic saveReqPrev;
	logic sdAckPrev;
	logic [7:0] lastSector;
	logic startXfer;

	// Image size differs between card only and card plus backup RAM
	assign lastSector = ((systemType == neoPkg::CD) || (systemType == neoPkg::CDZ)) ?
		`NEO_LAST_SECTOR_CD : `NEO_LAST_SECTOR_CART;

	// New transfer on a pending load or a save request edge
	assign startXfer = (state == IDLE) && enable && (loadPending || (~saveReqPrev & saveReq));

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			state <= IDLE;
			enable <= 1'b0;
			loadPending <= 1'b0;
			loading <= 1'b0;
			downloadingPrev <= 1'b0;
			saveReqPrev <= 1'b0;
			sdAckPrev <= 1'b0;
			sdRd <= 1'b0;
			sdWr <= 1'b0;
			sdLba <= '0;
		end
		else
		begin
			downloadingPrev <= downloading;
			saveReqPrev <= saveReq;
			sdAckPrev <= sdAck;

			// ==========================================================
			// Enable and pending load
			// ==========================================================

			// No image access while a download runs
			if (~downloadingPrev & downloading)
				enable <= 1'b0;
			if (~downloading && imgMounted && imgSizeNonzero && ~imgReadonly)
				enable <= 1'b1;

			// Image is read back once the download ends
			if (startXfer)
				loadPending <= 1'b0;
			if (downloadingPrev & ~downloading)
				loadPending <= 1'b1;

			// ==========================================================
			// Sector requests
			// ==========================================================

			// Host took the request
			if (~sdAckPrev & sdAck)
			begin
				sdRd <= 1'b0;
				sdWr <= 1'b0;
			end
			else if (state == IDLE)
			begin
				if (startXfer)
				begin
					state <= XFER;
					loading <= loadPending;
					sdLba <= '0;
					sdRd <= loadPending;
					sdWr <= ~loadPending;
				end
			end
			else if (sdAckPrev & ~sdAck)
			begin
				// Sector done, stop at the last one
				if (sdLba[7:0] >= lastSector)
					state <= IDLE;
				else
				begin
					sdLba <= sdLba + 1'b1;
					sdRd <= loading;
					sdWr <= ~loading;
				end
			end
		end
	end

endmodule

//--- hdl/ramClearSequencer.sv
// Work RAM clear sequencer
// Fills work RAM with address patterns after reset while the CPU is held
`timescale 1ns/100ps
`include "neoSupport_settings.svh"

module ramClearSequencer
(
	input logic clk_sys,
	input logic nBNKB,
	input logic sysReset,
	input logic [`NEO_WRAM_AW-1:0] cpuWramAddr,
	input neoPkg::wramWordT cpuWramData,
	input logic cpuWriteL,
	input logic cpuWriteU,
	output logic [`NEO_WRAM_AW-1:0] wramAddr,
	output neoPkg::wramWordT wramData,
	output logic wramWriteL,
	output logic wramWriteU,
	output logic cpuResetN
);

	logic sysResetPrev;
	logic clearing;
	logic [`NEO_CLEAR_W-1:0] clearCount;

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			// Counts as still in reset, so a low sysReset starts a sweep
			sysResetPrev <= 1'b1;
			clearing <= 1'b0;
			clearCount <= '0;
			cpuResetN <= 1'b0;
		end
		else
		begin
			sysResetPrev <= sysReset;
			// Host reset asserted
			if (~sysResetPrev & sysReset)
				cpuResetN <= 1'b0;
			// Host reset released, sweep from word 0
			if (sysResetPrev & ~sysReset)
			begin
				clearing <= 1'b1;
				clearCount <= '0;
			end
			else if (clearing)
			begin
				// Last word written, let the CPU run
				if (&clearCount)
				begin
					clearing <= 1'b0;
					cpuResetN <= 1'b1;
				end
				else
					clearCount <= clearCount + 1'b1;
			end
		end
	end

	// Sweep owns the RAM port, CPU the rest of the time
	assign wramAddr = clearing ? clearCount[`NEO_WRAM_AW-1:0] : cpuWramAddr;
	assign wramData = clearing ? neoPkg::wramWordT'(clearCount) : cpuWramData;
	assign wramWriteL = clearing | cpuWriteL;
	assign wramWriteU = clearing | cpuWriteU;

endmodule

//--- hdl/videoOut.sv
// Palette to DAC output stage
// Latches the palette word at pixel rate and expands it to 8-bit RGB
`timescale 1ns/100ps

module videoOut
(
	input logic clk_sys,
	input logic nBNKB,
	input logic pixelCe,
	input neoPkg::palEntryT palData,
	input logic videoEn,
	input logic chBlank,
	input logic screenBlank,
	output neoPkg::rgbT vgaR,
	output neoPkg::rgbT vgaG,
	output neoPkg::rgbT vgaB,
	output logic vgaDe
);

	neoPkg::palEntryT palLatch;

	// DAC latch
	// Blanked or disabled video shows black
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
			palLatch <= '0;
		else if (pixelCe)
			palLatch <= (screenBlank || !videoEn) ? '0 : palData;
	end

	// 4-bit colour, own LSB, shared dark bit, then zero fill
	assign vgaR = {palLatch[11:8], palLatch[14], palLatch[15], 2'b00};
	assign vgaG = {palLatch[7:4], palLatch[13], palLatch[15], 2'b00};
	assign vgaB = {palLatch[3:0], palLatch[12], palLatch[15], 2'b00};

	// Active area only
	assign vgaDe = ~chBlank & ~screenBlank;

endmodule

//--- hdl/neoSupport.sv
// Console support logic top level
// ROM download mapping, save image transfer, work RAM clear and video output
`timescale 1ns/100ps
`include "neoSupport_settings.svh"

module neoSupport
(
	input logic clk_sys,
	input logic nBNKB,
	// Host download and system selection
	input logic downloading,
	input neoPkg::romIndexT ioctlIndex,
	input logic [`NEO_IOCTL_AW-1:0] ioctlAddr,
	input logic ioctlWr,
	input neoPkg::systemTypeT systemType,
	output neoPkg::sdramAddrT sdramAddr,
	output logic sdramWe,
	output logic loRomWe,
	output logic z80RomWe,
	// Save image block requests
	input logic imgMounted,
	input logic imgSizeNonzero,
	input logic imgReadonly,
	input logic saveReq,
	input logic sdAck,
	output logic sdRd,
	output logic sdWr,
	output logic [`NEO_LBA_W-1:0] sdLba,
	// Work RAM and CPU reset
	input logic sysReset,
	input logic [`NEO_WRAM_AW-1:0] cpuWramAddr,
	input neoPkg::wramWordT cpuWramData,
	input logic cpuWriteL,
	input logic cpuWriteU,
	output logic [`NEO_WRAM_AW-1:0] wramAddr,
	output neoPkg::wramWordT wramData,
	output logic wramWriteL,
	output logic wramWriteU,
	output logic cpuResetN,
	// Video
	input logic pixelCe,
	input neoPkg::palEntryT palData,
	input logic videoEn,
	input logic chBlank,
	input logic screenBlank,
	output neoPkg::rgbT vgaR,
	output neoPkg::rgbT vgaG,
	output neoPkg::rgbT vgaB,
	output logic vgaDe
);

	// ==========================================================
	// Loading and save image
	// ==========================================================

	romLoadMapper romLoadMapperInst
	(
		.clk_sys(clk_sys), .nBNKB(nBNKB),
		.downloading(downloading), .ioctlIndex(ioctlIndex), .ioctlAddr(ioctlAddr),
		.ioctlWr(ioctlWr), .systemType(systemType),
		.sdramAddr(sdramAddr), .sdramWe(sdramWe), .loRomWe(loRomWe), .z80RomWe(z80RomWe)
	);

	saveSequencer saveSequencerInst
	(
		.clk_sys(clk_sys), .nBNKB(nBNKB),
		.downloading(downloading), .imgMounted(imgMounted),
		.imgSizeNonzero(imgSizeNonzero), .imgReadonly(imgReadonly),
		.saveReq(saveReq), .systemType(systemType), .sdAck(sdAck),
		.sdRd(sdRd), .sdWr(sdWr), .sdLba(sdLba)
	);

	// ==========================================================
	// Work RAM and video
	// ==========================================================

	ramClearSequencer ramClearSequencerInst
	(
		.clk_sys(clk_sys), .nBNKB(nBNKB), .sysReset(sysReset),
		.cpuWramAddr(cpuWramAddr), .cpuWramData(cpuWramData),
		.cpuWriteL(cpuWriteL), .cpuWriteU(cpuWriteU),
		.wramAddr(wramAddr), .wramData(wramData),
		.wramWriteL(wramWriteL), .wramWriteU(wramWriteU), .cpuResetN(cpuResetN)
	);

	videoOut videoOutInst
	(
		.clk_sys(clk_sys), .nBNKB(nBNKB), .pixelCe(pixelCe), .palData(palData),
		.videoEn(videoEn), .chBlank(chBlank), .screenBlank(screenBlank),
		.vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB), .vgaDe(vgaDe)
	);

endmodule

//--- sim/tbClock.sv
// Testbench clock and reset
// 8 ns system clock, reset held low for the first two cycles
`timescale 1ns/100ps

module tbClock
(
	output logic clk_sys,
	output logic nBNKB
);

	localparam int PERIOD = 8;

	initial
	begin
		clk_sys = 1'b0;
		forever
			#(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Released on a falling edge, away from the capture edge
	initial
	begin
		nBNKB = 1'b0;
		#(2 * PERIOD);
		nBNKB = 1'b1;
	end

endmodule

//--- sim/tbNeoSupport.sv
// Support logic testbench
// Pattern driven mapper and video checks, block device host model and RAM clear sweep
`timescale 1ns/100ps
`include "neoSupport_settings.svh"

module tbNeoSupport;

	localparam int PERIOD = 8;
	// Random delay of up to 8, ack held 2, then 2 turnaround cycles
	localparam int ACK_CYCLES = 12;
	// Two loads and one save, worst case
	localparam int SECTORS = 16 + 132 + 132;
	localparam int CLEAR_CYCLES = 65536;
	localparam int MARGIN = 4;

	logic clk_sys;
	logic nBNKB;
	logic downloading;
	neoPkg::romIndexT ioctlIndex;
	logic [`NEO_IOCTL_AW-1:0] ioctlAddr;
	logic ioctlWr;
	neoPkg::systemTypeT systemType;
	neoPkg::sdramAddrT sdramAddr;
	logic sdramWe;
	logic loRomWe;
	logic z80RomWe;
	logic imgMounted;
	logic imgSizeNonzero;
	logic imgReadonly;
	logic saveReq;
	logic sdAck;
	logic sdRd;
	logic sdWr;
	logic [`NEO_LBA_W-1:0] sdLba;
	logic sysReset;
	logic [`NEO_WRAM_AW-1:0] cpuWramAddr;
	neoPkg::wramWordT cpuWramData;
	logic cpuWriteL;
	logic cpuWriteU;
	logic [`NEO_WRAM_AW-1:0] wramAddr;
	neoPkg::wramWordT wramData;
	logic wramWriteL;
	logic wramWriteU;
	logic cpuResetN;
	logic pixelCe;
	neoPkg::palEntryT palData;
	logic videoEn;
	logic chBlank;
	logic screenBlank;
	neoPkg::rgbT vgaR;
	neoPkg::rgbT vgaG;
	neoPkg::rgbT vgaB;
	logic vgaDe;

	// Run bookkeeping
	int errorCount = 0;
	int testErrors = 0;
	int testCount = 0;
	int failedTests = 0;
	int checkCount = 0;
	// Requests seen by the host model in the current transfer
	int readCount = 0;
	int writeCount = 0;
	integer seed = 32'h02608caf;
	bit patternsRead = 1'b0;
	string mapLines[$];
	string vidLines[$];

	tbClock clockGen (.clk_sys(clk_sys), .nBNKB(nBNKB));

	neoSupport dut (.*);

	// ==========================================================
	// Checks and reporting
	// ==========================================================

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
		begin
			$display("FAIL %s: got %h, expected %h", name, actual, expected);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic reportProblem(input string text);
		$display("%s", text);
		errorCount++;
		testErrors++;
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (testErrors != 0)
			failedTests++;
		$display("test %-12s %s, %0d mismatches", name,
			(testErrors == 0) ? "passed" : "failed", testErrors);
		testErrors = 0;
	endtask

	// ==========================================================
	// Host block device model
	// ==========================================================

	// Answers each sector request after 1 to 8 cycles and holds ack for 2
	initial
	begin : hostModel
		int delay;
		sdAck = 1'b0;
		forever
		begin
			@(negedge clk_sys);
			if (sdRd || sdWr)
			begin
				// One direction per request
				checkValue("sdRd and sdWr", sdRd & sdWr, 1'b0);
				// Sectors come in order from 0
				checkValue("sdLba", sdLba, readCount + writeCount);
				if (sdRd)
					readCount++;
				else
					writeCount++;
				delay = 1 + ($unsigned($random(seed)) % 8);
				repeat (delay)
					@(negedge clk_sys);
				sdAck = 1'b1;
				repeat (2)
					@(negedge clk_sys);
				sdAck = 1'b0;
			end
		end
	end

	// Done once 16 cycles pass with no request and no ack
	task automatic waitHostIdle(input int limit);
		int quiet;
		int cycles;
		quiet = 0;
		cycles = 0;
		while (quiet < 16 && cycles < limit)
		begin
			@(negedge clk_sys);
			cycles++;
			if (sdRd || sdWr || sdAck)
				quiet = 0;
			else
				quiet++;
		end
		if (quiet < 16)
			reportProblem("save image transfer did not finish in time");
	endtask

	task automatic runTransfer(input string name, input int reads, input int writes);
		waitHostIdle(SECTORS * ACK_CYCLES);
		checkValue({name, " reads"}, readCount, reads);
		checkValue({name, " writes"}, writeCount, writes);
		finishTest(name);
	endtask

	// Drops downloading with a mounted image so that a load follows
	task automatic startLoad(input neoPkg::systemTypeT sysType);
		downloading = 1'b1;
		systemType = sysType;
		repeat (2)
			@(negedge clk_sys);
		readCount = 0;
		writeCount = 0;
		downloading = 1'b0;
	endtask

	task automatic pulseSaveReq();
		saveReq = 1'b1;
		repeat (2)
			@(negedge clk_sys);
		saveReq = 1'b0;
	endtask

	// ==========================================================
	// Pattern and CPU stimulus
	// ==========================================================

	// Columns: downloading, index, address, system type, address, strobes
	task automatic applyMapper(input string line);
		logic dl;
		logic [7:0] idx;
		logic [24:0] addr;
		logic [1:0] sys;
		logic [24:0] expAddr;
		logic [2:0] expWe;
		void'($sscanf(line, "M %h %h %h %h %h %h", dl, idx, addr, sys, expAddr, expWe));
		downloading = dl;
		ioctlIndex = neoPkg::romIndexT'(idx);
		ioctlAddr = addr;
		systemType = neoPkg::systemTypeT'(sys);
		ioctlWr = 1'b1;
		@(negedge clk_sys);
		ioctlWr = 1'b0;
		checkValue("sdramAddr", sdramAddr, expAddr);
		checkValue("sdramWe", sdramWe, expWe[2]);
		checkValue("loRomWe", loRomWe, expWe[1]);
		checkValue("z80RomWe", z80RomWe, expWe[0]);
	endtask

	// Columns: palette, videoEn, chBlank, screenBlank, R, G, B, display enable
	task automatic applyVideo(input string line);
		logic [15:0] pal;
		logic en;
		logic cb;
		logic sb;
		logic [7:0] expR;
		logic [7:0] expG;
		logic [7:0] expB;
		logic expDe;
		void'($sscanf(line, "V %h %h %h %h %h %h %h %h", pal, en, cb, sb,
			expR, expG, expB, expDe));
		palData = pal;
		videoEn = en;
		chBlank = cb;
		screenBlank = sb;
		pixelCe = 1'b1;
		@(negedge clk_sys);
		pixelCe = 1'b0;
		checkValue("vgaR", vgaR, expR);
		checkValue("vgaG", vgaG, expG);
		checkValue("vgaB", vgaB, expB);
		checkValue("vgaDe", vgaDe, expDe);
	endtask

	// CPU write outside clearing reaches the RAM port as driven
	task automatic cpuWrite(input logic [14:0] addr, input logic [15:0] data,
		input logic wl, input logic wu);
		cpuWramAddr = addr;
		cpuWramData = data;
		cpuWriteL = wl;
		cpuWriteU = wu;
		@(negedge clk_sys);
		checkValue("wramAddr", wramAddr, addr);
		checkValue("wramData", wramData, data);
		checkValue("wramWriteL", wramWriteL, wl);
		checkValue("wramWriteU", wramWriteU, wu);
		cpuWriteL = 1'b0;
		cpuWriteU = 1'b0;
	endtask

	// Releases the host reset and follows the whole sweep
	task automatic runClear();
		int writes;
		int cycles;
		bit done;
		writes = 0;
		cycles = 0;
		done = 1'b0;
		checkValue("cpuResetN", cpuResetN, 1'b0);
		sysReset = 1'b0;
		while (!done && cycles < CLEAR_CYCLES + 16)
		begin
			@(negedge clk_sys);
			cycles++;
			if (wramWriteL && wramWriteU)
			begin
				checkValue("wramData", wramData, writes);
				checkValue("wramAddr", wramAddr, writes % 32768);
				checkValue("cpuResetN", cpuResetN, 1'b0);
				writes++;
			end
			else if (writes != 0)
				done = 1'b1;
		end
		if (!done)
			reportProblem("work RAM clear did not end in time");
		checkValue("clear writes", writes, CLEAR_CYCLES);
		// First cycle after the last write
		checkValue("cpuResetN", cpuResetN, 1'b1);
	endtask

	// ==========================================================
	// Test sequence
	// ==========================================================

	initial
	begin : main
		int fd;
		string line;
		downloading = 1'b0;
		ioctlIndex = neoPkg::SPROM;
		ioctlAddr = '0;
		ioctlWr = 1'b0;
		systemType = neoPkg::ARCADE;
		imgMounted = 1'b0;
		imgSizeNonzero = 1'b0;
		imgReadonly = 1'b0;
		saveReq = 1'b0;
		// Host reset held until the clear test
		sysReset = 1'b1;
		cpuWramAddr = '0;
		cpuWramData = '0;
		cpuWriteL = 1'b0;
		cpuWriteU = 1'b0;
		pixelCe = 1'b0;
		palData = '0;
		videoEn = 1'b0;
		chBlank = 1'b0;
		screenBlank = 1'b0;

		fd = $fopen("sim/neoSupport_patterns.txt", "r");
		if (fd == 0)
			reportProblem("cannot open the pattern file sim/neoSupport_patterns.txt");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) == "M")
					mapLines.push_back(line);
				else if (line.len() > 0 && line.getc(0) == "V")
					vidLines.push_back(line);
			end
			$fclose(fd);
		end
		patternsRead = 1'b1;

		wait (nBNKB === 1'b1);
		@(negedge clk_sys);

		foreach (mapLines[i])
			applyMapper(mapLines[i]);
		finishTest("romMapper");

		// Loads, then a save, all with a writable image
		imgMounted = 1'b1;
		imgSizeNonzero = 1'b1;
		startLoad(neoPkg::CD);
		runTransfer("loadCd", 16, 0);
		startLoad(neoPkg::ARCADE);
		runTransfer("loadArcade", 132, 0);
		readCount = 0;
		writeCount = 0;
		pulseSaveReq();
		runTransfer("save", 0, 132);

		// Save request while a download runs, then a read-only image
		readCount = 0;
		writeCount = 0;
		downloading = 1'b1;
		repeat (2)
			@(negedge clk_sys);
		pulseSaveReq();
		waitHostIdle(64);
		checkValue("requests while downloading", readCount + writeCount, 0);
		imgReadonly = 1'b1;
		startLoad(neoPkg::ARCADE);
		pulseSaveReq();
		waitHostIdle(64);
		checkValue("blocked requests", readCount + writeCount, 0);
		finishTest("saveBlocked");

		runClear();
		cpuWrite(15'h1234, 16'hbeef, 1'b1, 1'b0);
		cpuWrite(15'h7ffe, 16'h5a0f, 1'b0, 1'b1);
		// Host reset again holds the CPU
		sysReset = 1'b1;
		@(negedge clk_sys);
		checkValue("cpuResetN", cpuResetN, 1'b0);
		finishTest("ramClear");

		foreach (vidLines[i])
			applyVideo(vidLines[i]);
		finishTest("videoOut");

		$display("tests %0d, failed %0d, checks %0d, mismatches %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Run length from the clear sweep, worst case sectors and pattern count
	initial
	begin : watchdog
		int limitCycles;
		wait (patternsRead);
		limitCycles = (CLEAR_CYCLES + SECTORS * ACK_CYCLES + mapLines.size() +
			vidLines.size()) * MARGIN;
		#(limitCycles * PERIOD);
		$display("watchdog timeout after %0d cycles, run stopped", limitCycles);
		$display("Errors found");
		$finish;
	end

endmodule

//--- neoSupport.f
+incdir+hdl
hdl/neoPkg.sv
hdl/romLoadMapper.sv
hdl/saveSequencer.sv
hdl/ramClearSequencer.sv
hdl/videoOut.sv
hdl/neoSupport.sv
sim/tbClock.sv
sim/tbNeoSupport.sv

//--- Bender.yml
package:
  name: neoSupport

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/neoPkg.sv
      - hdl/romLoadMapper.sv
      - hdl/saveSequencer.sv
      - hdl/ramClearSequencer.sv
      - hdl/videoOut.sv
      - hdl/neoSupport.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tbClock.sv
      - sim/tbNeoSupport.sv

//--- sim/neoSupport_patterns.txt
# M downloading index address systemType(0 CONSOLE 1 ARCADE 2 CD 3 CDZ) sdramAddr strobes(sdramWe loRomWe z80RomWe)
# V palette videoEn chBlank screenBlank vgaR vgaG vgaB vgaDe
M 1 00 0012345 1 0612345 4
M 1 00 0000010 2 0600010 4
M 1 01 0000020 1 0000000 2
M 1 09 0000030 1 0000000 1
M 1 02 0034567 1 0634567 4
M 1 08 0123456 2 06a3456 0
M 1 04 0f12345 1 0012345 4
M 1 05 0087654 0 0087654 4
M 1 06 0100000 1 0300000 4
M 1 40 0001234 1 0802468 4
M 1 47 0010000 1 0b20002 4
M 1 7f 0ffffff 0 0700000 4
M 1 03 0001111 1 0000000 4
M 1 01 0000040 3 0000000 2
M 1 09 0000050 2 0000000 1
M 0 00 0000001 1 0600001 0
V ffff 1 0 0 fc fc fc 1
V 0123 1 0 0 10 20 30 1
V 4a5c 1 1 0 a8 50 c0 0
V 8f00 1 0 0 f4 04 04 1
V 3abc 1 0 0 a0 b8 c8 1
V 2777 0 0 0 00 00 00 1
V 1fff 1 0 1 00 00 00 0
